// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the stream merge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
  --top-module stream_merge_tb -f verilog.f \
  --Mdir obj_dir -o stream_merge_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

sim_out=$(./obj_dir/stream_merge_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== src/arbiter_m2s.sv ====
// Round-robin burst arbiter that merges all port streams onto one output
`timescale 1ns/100ps
`include "stream_merge_cfg.svh"

module arbiter_m2s import stream_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  // --------------------
  // Port streams
  // --------------------

  input  logic  [`NR_OF_PORTS-1:0]      mst_valid,
  output logic  [`NR_OF_PORTS-1:0]      mst_ready,
  input  beat_t [`NR_OF_PORTS-1:0]      mst_beat,

  // --------------------
  // Merged stream
  // --------------------

  output logic                          slv_valid,
  input  logic                          slv_ready,
  output beat_t                         slv_beat
);

  localparam int PTR_W = $clog2(`NR_OF_PORTS);

  arbiter_state_t   arbiter_state;

  // Port examined in the current FIND cycle
  logic [PTR_W-1:0] rotating_mst;
  // Port that owns the output until its last beat
  logic [PTR_W-1:0] grant_idx;
  logic             last_fire;

  // Handshake of the closing beat ends the grant
  assign last_fire = slv_valid && slv_ready && slv_beat.last;

  // --------------------
  // FSM
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arbiter_state <= FIND_MST_VALID_E;
      rotating_mst  <= '0;
      grant_idx     <= '0;
    end else begin
      case (arbiter_state)

        FIND_MST_VALID_E: begin
          // Scan only while the sink can take data
          if (slv_ready) begin
            if (rotating_mst == PTR_W'(`NR_OF_PORTS - 1)) begin
              rotating_mst <= '0;
            end else begin
              rotating_mst <= rotating_mst + 1'b1;
            end

            // Valid port found, first beat goes out next cycle
            if (mst_valid[rotating_mst]) begin
              arbiter_state <= WAIT_MST_LAST_E;
              grant_idx     <= rotating_mst;
            end
          end
        end

        WAIT_MST_LAST_E: begin
          // Search resumes after the granted port in the next cycle
          if (last_fire) begin
            arbiter_state <= FIND_MST_VALID_E;
          end
        end

        default: begin
          arbiter_state <= FIND_MST_VALID_E;
        end

      endcase
    end
  end

  // --------------------
  // Output multiplexer
  // --------------------

  always_comb begin
    slv_valid = 1'b0;
    slv_beat  = '0;
    mst_ready = '0;

    // Only the granted port sees ready, all others stall
    if (arbiter_state == WAIT_MST_LAST_E) begin
      slv_valid            = mst_valid[grant_idx];
      slv_beat             = mst_beat[grant_idx];
      mst_ready[grant_idx] = slv_ready;
    end
  end

endmodule

// ==== src/axil_pkg.sv ====
// AXI4-Lite bus types and register map of the merge unit control port
`include "stream_merge_cfg.svh"

package axil_pkg;

  // Response codes on bresp and rresp
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // --------------------
  // Bus signals
  // --------------------

  // Everything driven by the manager
  typedef struct packed {
    logic                        awvalid;
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr;
    logic                        wvalid;
    logic [31:0]                 wdata;
    logic [3:0]                  wstrb;
    logic                        bready;
    logic                        arvalid;
    logic [`AXIL_ADDR_WIDTH-1:0] araddr;
    logic                        rready;
  } axil_req_t;

  // Everything driven by the subordinate
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    axil_resp_t  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    axil_resp_t  rresp;
  } axil_rsp_t;

  // --------------------
  // Register map
  // --------------------

  // Byte offsets, one 32-bit word per register
  typedef enum logic [`AXIL_ADDR_WIDTH-1:0] {
    REG_CTRL       = `AXIL_ADDR_WIDTH'('h00),
    REG_BURST_CNT0 = `AXIL_ADDR_WIDTH'('h04),
    REG_BURST_CNT1 = `AXIL_ADDR_WIDTH'('h08),
    REG_BURST_CNT2 = `AXIL_ADDR_WIDTH'('h0C),
    REG_BURST_CNT3 = `AXIL_ADDR_WIDTH'('h10),
    REG_BEAT_CNT   = `AXIL_ADDR_WIDTH'('h14)
  } csr_addr_t;

endpackage

// ==== src/beat_fifo.sv ====
// Per-port input buffer that only admits new bursts while the port is enabled
`timescale 1ns/100ps
`include "stream_merge_cfg.svh"

module beat_fifo import stream_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  port_enable,

  // Source side
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,

  // Arbiter side
  output logic  buf_valid,
  input  logic  buf_ready,
  output beat_t buf_beat
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  beat_t            mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             in_burst;
  logic             running;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CNT_W'(`FIFO_DEPTH));

  // An open burst is always completed, a new one needs the enable bit
  // running keeps in_ready low until the first edge after reset
  assign in_ready = running && !full && (port_enable || in_burst);

  assign push = in_valid && in_ready;
  assign pop  = buf_valid && buf_ready;

  // Head of the buffer, visible the cycle after the write
  assign buf_valid = (count != '0);
  assign buf_beat  = mem[rd_ptr];

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // --------------------
  // Pointers and state
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_burst <= 1'b0;
      running  <= 1'b0;
    end else begin
      running <= 1'b1;

      // Circular pointers wrap at the last entry
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end

      // Push and pop in one cycle leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end

      // Burst stays open until its last beat has been accepted
      if (push) begin
        in_burst <= !in_beat.last;
      end
    end
  end

endmodule

// ==== src/merge_csr.sv ====
// AXI4-Lite register block with port enable mask, burst counters per id and beat counter
`timescale 1ns/100ps
`include "stream_merge_cfg.svh"

module merge_csr import stream_pkg::*; import axil_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,

  // Register port
  input  axil_req_t               s_axil_req,
  output axil_rsp_t               s_axil_rsp,

  // Enable bit per source port
  output logic [`NR_OF_PORTS-1:0] port_enable,

  // Merged output, observed only
  input  logic                    out_valid,
  input  logic                    out_ready,
  input  beat_t                   out_beat
);

  localparam int NR_OF_IDS = 1 << `ID_WIDTH;

  logic [`NR_OF_PORTS-1:0] enable_mask;
  logic [31:0]             burst_cnt [NR_OF_IDS];
  logic [31:0]             beat_cnt;

  // Write response channel
  logic                    bvalid_q;
  axil_resp_t              bresp_q;

  // Read data channel
  logic                    rvalid_q;
  axil_resp_t              rresp_q;
  logic [31:0]             rdata_q;

  logic                    wr_fire;
  logic                    rd_fire;
  logic                    out_fire;
  logic                    clear_cnt;
  axil_resp_t              wr_resp;
  axil_resp_t              rd_resp;
  logic [31:0]             rd_word;

  // Address and data accepted together, one write in flight
  assign wr_fire  = s_axil_req.awvalid && s_axil_req.wvalid && !bvalid_q;
  // One read in flight
  assign rd_fire  = s_axil_req.arvalid && !rvalid_q;
  assign out_fire = out_valid && out_ready;

  // Any write to the beat counter clears every counter
  assign clear_cnt = wr_fire && (s_axil_req.awaddr == REG_BEAT_CNT);

  assign port_enable = enable_mask;

  // --------------------
  // Address decode
  // --------------------

  always_comb begin
    wr_resp = RESP_OKAY;
    case (s_axil_req.awaddr)
      REG_CTRL, REG_BURST_CNT0, REG_BURST_CNT1,
      REG_BURST_CNT2, REG_BURST_CNT3, REG_BEAT_CNT: wr_resp = RESP_OKAY;
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (s_axil_req.araddr)
      REG_CTRL:       rd_word[`NR_OF_PORTS-1:0] = enable_mask;
      REG_BURST_CNT0: rd_word = burst_cnt[0];
      REG_BURST_CNT1: rd_word = burst_cnt[1];
      REG_BURST_CNT2: rd_word = burst_cnt[2];
      REG_BURST_CNT3: rd_word = burst_cnt[3];
      REG_BEAT_CNT:   rd_word = beat_cnt;
      // Unmapped offset reads zero with an error
      default:        rd_resp = RESP_SLVERR;
    endcase
  end

  // --------------------
  // Bus handshakes
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RESP_OKAY;
      rvalid_q <= 1'b0;
      rresp_q  <= RESP_OKAY;
    end else begin
      // bvalid one cycle after the write, held until bready
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_resp;
      end else if (s_axil_req.bready) begin
        bvalid_q <= 1'b0;
      end

      // rvalid one cycle after arvalid, held until rready
      if (rd_fire) begin
        rvalid_q <= 1'b1;
        rresp_q  <= rd_resp;
      end else if (s_axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Read data captured with the address
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    s_axil_rsp         = '0;
    s_axil_rsp.awready = wr_fire;
    s_axil_rsp.wready  = wr_fire;
    s_axil_rsp.bvalid  = bvalid_q;
    s_axil_rsp.bresp   = bresp_q;
    s_axil_rsp.arready = !rvalid_q;
    s_axil_rsp.rvalid  = rvalid_q;
    s_axil_rsp.rdata   = rdata_q;
    s_axil_rsp.rresp   = rresp_q;
  end

  // --------------------
  // Control and counters
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_mask <= '1;
      beat_cnt    <= '0;
      for (int i = 0; i < NR_OF_IDS; i++) begin
        burst_cnt[i] <= '0;
      end
    end else begin
      // Mask bits live in the lowest byte lane
      if (wr_fire && s_axil_req.awaddr == REG_CTRL && s_axil_req.wstrb[0]) begin
        enable_mask <= s_axil_req.wdata[`NR_OF_PORTS-1:0];
      end

      // Clear wins over a beat in the same cycle
      if (clear_cnt) begin
        beat_cnt <= '0;
        for (int i = 0; i < NR_OF_IDS; i++) begin
          burst_cnt[i] <= '0;
        end
      end else if (out_fire) begin
        beat_cnt <= beat_cnt + 1'b1;
        // Burst counted on its closing beat
        if (out_beat.last) begin
          burst_cnt[out_beat.id] <= burst_cnt[out_beat.id] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== src/stream_merge_cfg.svh ====
// Stream merge configuration: port count, stream widths, buffer depth, register map width
`ifndef STREAM_MERGE_CFG_SVH
`define STREAM_MERGE_CFG_SVH

// --------------------
// Stream ports
// --------------------

// Number of burst sources merged onto the output
`define NR_OF_PORTS 4

// Payload width of one beat
`define DATA_WIDTH 32

// Width of the burst id carried with each beat
`define ID_WIDTH 2

// Entries in each per-port input buffer
`define FIFO_DEPTH 8

// --------------------
// Register port
// --------------------

// Byte address width of the AXI4-Lite register port
`define AXIL_ADDR_WIDTH 8

`endif

// ==== src/stream_merge_top.sv ====
// Stream merge unit top: port buffers, burst arbiter and AXI4-Lite register block
`timescale 1ns/100ps
`include "stream_merge_cfg.svh"

module stream_merge_top import stream_pkg::*; import axil_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  // Source streams
  input  logic  [`NR_OF_PORTS-1:0]      in_valid,
  output logic  [`NR_OF_PORTS-1:0]      in_ready,
  input  beat_t [`NR_OF_PORTS-1:0]      in_beat,

  // Merged output stream
  output logic                          out_valid,
  input  logic                          out_ready,
  output beat_t                         out_beat,

  // Register port
  input  axil_req_t                     s_axil_req,
  output axil_rsp_t                     s_axil_rsp
);

  // Buffer outputs towards the arbiter
  logic  [`NR_OF_PORTS-1:0] buf_valid;
  logic  [`NR_OF_PORTS-1:0] buf_ready;
  beat_t [`NR_OF_PORTS-1:0] buf_beat;

  // Enable mask from the register block
  logic  [`NR_OF_PORTS-1:0] port_enable;

  // --------------------
  // Input buffers
  // --------------------

  for (genvar p = 0; p < `NR_OF_PORTS; p++) begin : g_port
    beat_fifo u_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .port_enable (port_enable[p]),
      .in_valid    (in_valid[p]),
      .in_ready    (in_ready[p]),
      .in_beat     (in_beat[p]),
      .buf_valid   (buf_valid[p]),
      .buf_ready   (buf_ready[p]),
      .buf_beat    (buf_beat[p])
    );
  end

  // --------------------
  // Arbiter
  // --------------------

  arbiter_m2s u_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .mst_valid (buf_valid),
    .mst_ready (buf_ready),
    .mst_beat  (buf_beat),
    .slv_valid (out_valid),
    .slv_ready (out_ready),
    .slv_beat  (out_beat)
  );

  // Registers watch the merged output
  merge_csr u_csr (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_axil_req  (s_axil_req),
    .s_axil_rsp  (s_axil_rsp),
    .port_enable (port_enable),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_beat    (out_beat)
  );

endmodule

// ==== src/stream_pkg.sv ====
// Stream types shared by the buffers, the burst arbiter and the register block
`include "stream_merge_cfg.svh"

package stream_pkg;

  // --------------------
  // Beat
  // --------------------

  // One transfer on any stream in the merge unit
  // 35 bits with the default widths
  typedef struct packed {
    // Payload
    logic [`DATA_WIDTH-1:0] data;
    // Set on the final beat of a burst
    logic                   last;
    // Burst id, kept unchanged from source to output
    logic [`ID_WIDTH-1:0]   id;
  } beat_t;

  // --------------------
  // Arbiter
  // --------------------

  // Burst arbiter states
  // FIND scans the ports one per cycle, WAIT holds the grant until last
  typedef enum logic {
    FIND_MST_VALID_E,
    WAIT_MST_LAST_E
  } arbiter_state_t;

endpackage

// ==== verif/stream_merge_tb.sv ====
// Stream merge testbench: table of bursts, per-port drivers, output scoreboard and AXI4-Lite checks
`timescale 1ns/100ps
`include "stream_merge_cfg.svh"

module stream_merge_tb import stream_pkg::*; import axil_pkg::*; ();

  localparam int NR_ROWS      = 18;
  localparam int TIMEOUT      = 2000;
  localparam int BLOCK_CYCLES = 30;
  localparam int QUIET_CYCLES = 10;

  // One queued burst and how it is applied
  typedef struct packed {
    int          test;
    int          port;
    int          id;
    int          len;
    logic [31:0] start;
    bit          dis_first;
    bit          rnd_ready;
  } burst_row_t;

  logic                     clk;
  logic                     rst_n;
  logic  [`NR_OF_PORTS-1:0] in_valid;
  logic  [`NR_OF_PORTS-1:0] in_ready;
  beat_t [`NR_OF_PORTS-1:0] in_beat;
  logic                     out_valid;
  logic                     out_ready;
  beat_t                    out_beat;
  axil_req_t                s_axil_req;
  axil_rsp_t                s_axil_rsp;

  // Every beat seen on the merged output, in order
  beat_t      out_q [$];
  burst_row_t rows [NR_ROWS];
  int         seed = 32'h196e;
  bit         ready_random;
  int         err_count;
  int         pass_count;
  int         fail_count;

  stream_merge_top uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_beat    (in_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_beat   (out_beat),
    .s_axil_req (s_axil_req),
    .s_axil_rsp (s_axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Sink ready, always high or random per cycle
  initial begin
    int rnd;
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (ready_random) begin
        rnd       = $random(seed);
        out_ready = rnd[0];
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  // Collector, sampled mid-cycle where the handshake is settled
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      out_q.push_back(out_beat);
    end
  end

  // --------------------
  // Stimulus table
  // --------------------

  function automatic burst_row_t make_row(int test, int port, int id, int len,
                                          logic [31:0] start, bit dis_first, bit rnd_ready);
    burst_row_t r;
    r.test      = test;
    r.port      = port;
    r.id        = id;
    r.len       = len;
    r.start     = start;
    r.dis_first = dis_first;
    r.rnd_ready = rnd_ready;
    return r;
  endfunction

  task automatic fill_table();
    // Columns: test, port, id, length, start data, disable first, random ready
    rows[0]  = make_row(2, 1, 1, 5, 32'h0000_0100, 1'b0, 1'b0);
    rows[1]  = make_row(3, 0, 0, 3, 32'h0000_1000, 1'b0, 1'b0);
    rows[2]  = make_row(3, 1, 1, 4, 32'h0000_2000, 1'b0, 1'b0);
    rows[3]  = make_row(3, 2, 2, 2, 32'h0000_3000, 1'b0, 1'b0);
    rows[4]  = make_row(3, 3, 3, 6, 32'h0000_4000, 1'b0, 1'b0);
    rows[5]  = make_row(3, 0, 0, 4, 32'h0000_1100, 1'b0, 1'b0);
    rows[6]  = make_row(3, 1, 1, 2, 32'h0000_2100, 1'b0, 1'b0);
    rows[7]  = make_row(3, 2, 2, 5, 32'h0000_3100, 1'b0, 1'b0);
    rows[8]  = make_row(3, 3, 3, 1, 32'h0000_4100, 1'b0, 1'b0);
    // Longer than a buffer so sources see in_ready drop
    rows[9]  = make_row(4, 0, 0, 7, 32'h0000_5000, 1'b0, 1'b1);
    rows[10] = make_row(4, 1, 1, 1, 32'h0000_6000, 1'b0, 1'b1);
    rows[11] = make_row(4, 2, 2, 11, 32'h0000_7000, 1'b0, 1'b1);
    rows[12] = make_row(4, 3, 3, 3, 32'h0000_8000, 1'b0, 1'b1);
    rows[13] = make_row(4, 0, 0, 2, 32'h0000_5100, 1'b0, 1'b1);
    rows[14] = make_row(4, 1, 1, 6, 32'h0000_6100, 1'b0, 1'b1);
    rows[15] = make_row(5, 2, 2, 3, 32'h0000_9000, 1'b1, 1'b0);
    rows[16] = make_row(5, 0, 0, 4, 32'h0000_A000, 1'b0, 1'b0);
    rows[17] = make_row(5, 3, 3, 2, 32'h0000_B000, 1'b0, 1'b0);
  endtask

  // Expected beat i of a row, data counts up from the start value
  function automatic beat_t make_beat(int r, int i);
    beat_t b;
    b.data = rows[r].start + 32'(i);
    b.last = (i == rows[r].len - 1);
    b.id   = `ID_WIDTH'(rows[r].id);
    return b;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_beat(input string what, input beat_t got, input beat_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: %s expected data=%h last=%b id=%0d, got data=%h last=%b id=%0d",
               $time, what, exp.data, exp.last, exp.id, got.data, got.last, got.id);
    end
  endtask

  task automatic check_resp(input string what, input axil_resp_t got, input axil_resp_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: %s expected %s, got %s", $time, what, exp.name(), got.name());
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, what, exp, got);
    end
  endtask

  task automatic report_timeout(input string what);
    err_count++;
    $display("ERROR at %0t ns: gave up waiting for %s", $time, what);
  endtask

  // --------------------
  // AXI4-Lite manager
  // --------------------

  task automatic axil_write(input logic [`AXIL_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                            output axil_resp_t resp);
    int cyc;
    bit accepted;
    resp = RESP_SLVERR;
    @(posedge clk);
    #2;
    s_axil_req.awvalid = 1'b1;
    s_axil_req.awaddr  = addr;
    s_axil_req.wvalid  = 1'b1;
    s_axil_req.wdata   = data;
    s_axil_req.wstrb   = 4'hF;
    cyc = 0;
    @(negedge clk);
    while (!(s_axil_rsp.awready && s_axil_rsp.wready) && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    accepted = s_axil_rsp.awready && s_axil_rsp.wready;
    @(posedge clk);
    #2;
    s_axil_req.awvalid = 1'b0;
    s_axil_req.wvalid  = 1'b0;
    if (!accepted) begin
      report_timeout("awready and wready on a register write");
      return;
    end
    s_axil_req.bready = 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!s_axil_rsp.bvalid && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (s_axil_rsp.bvalid) begin
      resp = s_axil_rsp.bresp;
    end else begin
      report_timeout("bvalid on a register write");
    end
    @(posedge clk);
    #2;
    s_axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [`AXIL_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                           output axil_resp_t resp);
    int cyc;
    bit accepted;
    data = '0;
    resp = RESP_SLVERR;
    @(posedge clk);
    #2;
    s_axil_req.arvalid = 1'b1;
    s_axil_req.araddr  = addr;
    cyc = 0;
    @(negedge clk);
    while (!s_axil_rsp.arready && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    accepted = s_axil_rsp.arready;
    @(posedge clk);
    #2;
    s_axil_req.arvalid = 1'b0;
    if (!accepted) begin
      report_timeout("arready on a register read");
      return;
    end
    s_axil_req.rready = 1'b1;
    cyc = 0;
    @(negedge clk);
    while (!s_axil_rsp.rvalid && cyc < TIMEOUT) begin
      @(negedge clk);
      cyc++;
    end
    if (s_axil_rsp.rvalid) begin
      data = s_axil_rsp.rdata;
      resp = s_axil_rsp.rresp;
    end else begin
      report_timeout("rvalid on a register read");
    end
    @(posedge clk);
    #2;
    s_axil_req.rready = 1'b0;
  endtask

  // --------------------
  // Source drivers
  // --------------------

  task automatic send_burst(input int r);
    int p;
    int cyc;
    bit ok;
    p = rows[r].port;
    @(posedge clk);
    #2;
    for (int i = 0; i < rows[r].len; i++) begin
      in_beat[p]  = make_beat(r, i);
      in_valid[p] = 1'b1;
      cyc = 0;
      @(negedge clk);
      while (!in_ready[p] && cyc < TIMEOUT) begin
        @(negedge clk);
        cyc++;
      end
      ok = in_ready[p];
      @(posedge clk);
      #2;
      if (!ok) begin
        in_valid[p] = 1'b0;
        report_timeout($sformatf("in_ready on port %0d", p));
        return;
      end
    end
    in_valid[p] = 1'b0;
  endtask

  // Sends the rows of one port in table order
  task automatic drive_port(input int p, input int test_no);
    for (int r = 0; r < NR_ROWS; r++) begin
      if (rows[r].test == test_no && rows[r].port == p && !rows[r].dis_first) begin
        send_burst(r);
      end
    end
  endtask

  // Offers the first beat of a disabled port and expects it to be refused
  task automatic hold_blocked(input int r);
    int p;
    bit taken;
    if (r < 0) begin
      return;
    end
    p     = rows[r].port;
    taken = 1'b0;
    @(posedge clk);
    #2;
    in_beat[p]  = make_beat(r, 0);
    in_valid[p] = 1'b1;
    for (int c = 0; c < BLOCK_CYCLES; c++) begin
      @(negedge clk);
      if (in_ready[p]) begin
        taken = 1'b1;
      end
    end
    if (taken) begin
      err_count++;
      $display("ERROR at %0t ns: port %0d raised in_ready for a new burst while disabled",
               $time, p);
    end
  endtask

  task automatic wait_beats(input int base, input int n);
    int cyc;
    cyc = 0;
    while (out_q.size() - base < n && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (out_q.size() - base < n) begin
      report_timeout($sformatf("%0d output beats, %0d arrived", n, out_q.size() - base));
    end
  endtask

  // --------------------
  // Scoreboard
  // --------------------

  // Splits the output into bursts and pairs each with the oldest unmatched row of its id
  task automatic check_group(input int test_no, input int base);
    bit matched [NR_ROWS];
    int idx;
    int found;
    foreach (matched[k]) begin
      matched[k] = 1'b0;
    end
    idx = base;
    while (idx < out_q.size()) begin
      found = -1;
      for (int r = 0; r < NR_ROWS; r++) begin
        if (found < 0 && rows[r].test == test_no && !matched[r] &&
            rows[r].id == int'(out_q[idx].id)) begin
          found = r;
        end
      end
      if (found < 0) begin
        err_count++;
        $display("ERROR at %0t ns: output burst with id %0d matches no queued burst",
                 $time, out_q[idx].id);
        idx = out_q.size();
      end else begin
        matched[found] = 1'b1;
        for (int i = 0; i < rows[found].len && idx < out_q.size(); i++) begin
          check_beat($sformatf("out_beat row %0d beat %0d", found, i), out_q[idx],
                     make_beat(found, i));
          idx++;
        end
      end
    end
    for (int r = 0; r < NR_ROWS; r++) begin
      if (rows[r].test == test_no && !matched[r]) begin
        err_count++;
        $display("ERROR at %0t ns: burst of row %0d never reached the output", $time, r);
      end
    end
  endtask

  task automatic apply_group(input int test_no);
    int         base;
    int         exp_beats;
    int         open_beats;
    int         blocked;
    int         cyc;
    bit         rnd;
    axil_resp_t resp;
    base       = out_q.size();
    exp_beats  = 0;
    open_beats = 0;
    blocked    = -1;
    rnd        = 1'b0;
    for (int r = 0; r < NR_ROWS; r++) begin
      if (rows[r].test == test_no) begin
        exp_beats += rows[r].len;
        if (rows[r].dis_first) begin
          blocked = r;
        end else begin
          open_beats += rows[r].len;
        end
        rnd |= rows[r].rnd_ready;
      end
    end
    ready_random = rnd;
    // Enable change goes in before any beat of the group
    if (blocked >= 0) begin
      axil_write(REG_CTRL, 32'hF ^ (32'h1 << rows[blocked].port), resp);
      check_resp("bresp REG_CTRL", resp, RESP_OKAY);
    end
    fork
      drive_port(0, test_no);
      drive_port(1, test_no);
      drive_port(2, test_no);
      drive_port(3, test_no);
      hold_blocked(blocked);
    join
    // Enabled ports drain while the blocked one waits
    wait_beats(base, open_beats);
    if (blocked >= 0) begin
      // Held first beat goes through as soon as the enable bit is back
      fork
        begin
          axil_write(REG_CTRL, 32'hF, resp);
          check_resp("bresp REG_CTRL", resp, RESP_OKAY);
        end
        send_burst(blocked);
      join
      wait_beats(base, exp_beats);
    end
    ready_random = 1'b0;
    // Quiet window catches duplicated beats
    cyc = 0;
    while (cyc < QUIET_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    if (out_q.size() - base != exp_beats) begin
      err_count++;
      $display("ERROR at %0t ns: expected %0d output beats, saw %0d",
               $time, exp_beats, out_q.size() - base);
    end
    check_group(test_no, base);
  endtask

  // --------------------
  // Register tests
  // --------------------

  task automatic test_registers();
    logic [31:0] d;
    axil_resp_t  r;
    axil_read(REG_CTRL, d, r);
    check_resp("rresp REG_CTRL", r, RESP_OKAY);
    check_word("REG_CTRL", d, 32'hF);
    for (int n = 1; n <= 5; n++) begin
      axil_read(`AXIL_ADDR_WIDTH'(4 * n), d, r);
      check_resp($sformatf("rresp offset 0x%02h", 4 * n), r, RESP_OKAY);
      check_word($sformatf("counter at 0x%02h", 4 * n), d, 32'h0);
    end
    axil_write(REG_CTRL, 32'h5, r);
    check_resp("bresp REG_CTRL", r, RESP_OKAY);
    axil_read(REG_CTRL, d, r);
    check_word("REG_CTRL", d, 32'h5);
    axil_write(REG_CTRL, 32'hF, r);
    check_resp("bresp REG_CTRL", r, RESP_OKAY);
    // Unmapped offsets
    axil_read(`AXIL_ADDR_WIDTH'('h18), d, r);
    check_resp("rresp unmapped read", r, RESP_SLVERR);
    // Data differs from the mask so an aliased write would show up
    axil_write(`AXIL_ADDR_WIDTH'('h40), 32'h0000_0000, r);
    check_resp("bresp unmapped write", r, RESP_SLVERR);
    axil_read(REG_CTRL, d, r);
    check_word("REG_CTRL after unmapped write", d, 32'hF);
  endtask

  task automatic test_counters();
    int          exp_bursts [1 << `ID_WIDTH];
    int          exp_beats;
    logic [31:0] d;
    axil_resp_t  r;
    foreach (exp_bursts[k]) begin
      exp_bursts[k] = 0;
    end
    exp_beats = 0;
    // Every table row has been delivered once since reset
    for (int k = 0; k < NR_ROWS; k++) begin
      exp_bursts[rows[k].id]++;
      exp_beats += rows[k].len;
    end
    for (int n = 0; n < (1 << `ID_WIDTH); n++) begin
      axil_read(`AXIL_ADDR_WIDTH'(4 + 4 * n), d, r);
      check_word($sformatf("REG_BURST_CNT%0d", n), d, 32'(exp_bursts[n]));
    end
    axil_read(REG_BEAT_CNT, d, r);
    check_word("REG_BEAT_CNT", d, 32'(exp_beats));
    axil_write(REG_BEAT_CNT, 32'h0, r);
    check_resp("bresp REG_BEAT_CNT", r, RESP_OKAY);
    for (int n = 1; n <= 5; n++) begin
      axil_read(`AXIL_ADDR_WIDTH'(4 * n), d, r);
      check_word($sformatf("cleared counter at 0x%02h", 4 * n), d, 32'h0);
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %0d %s: ok", num, name);
    end else begin
      fail_count++;
      $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    int errs;
    rst_n        = 1'b0;
    in_valid     = '0;
    in_beat      = '0;
    s_axil_req   = '0;
    ready_random = 1'b0;
    err_count    = 0;
    pass_count   = 0;
    fail_count   = 0;
    fill_table();
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errs = err_count;
    test_registers();
    report_test(1, "registers after reset", errs);
    errs = err_count;
    apply_group(2);
    report_test(2, "single burst", errs);
    errs = err_count;
    apply_group(3);
    report_test(3, "all ports merged", errs);
    errs = err_count;
    apply_group(4);
    report_test(4, "random back-pressure", errs);
    errs = err_count;
    apply_group(5);
    report_test(5, "port enable gating", errs);
    errs = err_count;
    test_counters();
    report_test(6, "counters", errs);

    $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/stream_pkg.sv
src/axil_pkg.sv
src/beat_fifo.sv
src/arbiter_m2s.sv
src/merge_csr.sv
src/stream_merge_top.sv
verif/stream_merge_tb.sv
